// File: build.f
logic/stm_pkg.sv
logic/stm_cfg_if.sv
logic/stm_apb_regs.sv
logic/stm_idx_track.sv
logic/stm_time_trigger.sv
logic/stm_loop_counter.sv
logic/stm_swap_fsm.sv
logic/stm_top.sv
tb/stm_clkgen.sv
tb/stm_assert.sv
tb/stm_tb.sv

// File: Bender.yml
package:
  name: stm_swap

sources:
  - logic/stm_pkg.sv
  - logic/stm_cfg_if.sv
  - logic/stm_apb_regs.sv
  - logic/stm_idx_track.sv
  - logic/stm_time_trigger.sv
  - logic/stm_loop_counter.sv
  - logic/stm_swap_fsm.sv
  - logic/stm_top.sv
  - target: test
    files:
      - tb/stm_clkgen.sv
      - tb/stm_assert.sv
      - tb/stm_tb.sv

// File: tb/stm_tb.sv
`timescale 1ns/1ns
`default_nettype none

module stm_tb;

  localparam int max_cycles = 3000;
  localparam int cycle0_val = 3;
  localparam int cycle1_val = 4;
  localparam int rep0_val   = 2;
  localparam int rep1_val   = 1;
  localparam int wait_limit = 100;

  logic                             CLK;
  logic                             rst_n;
  logic [7:0]                       paddr;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [31:0]                      pwdata;
  logic [31:0]                      prdata;
  logic                             pready;
  logic                             pslverr;
  logic [stm_pkg::time_width-1:0]   sys_time;
  logic [stm_pkg::idx_width-1:0]    sync_idx0;
  logic [stm_pkg::idx_width-1:0]    sync_idx1;
  logic [3:0]                       gpio_in;
  logic                             stop;
  logic                             segment;
  logic [stm_pkg::idx_width-1:0]    idx0;
  logic [stm_pkg::idx_width-1:0]    idx1;

  logic                             idx_run;      // Sequencer model enable
  int                               step_period;
  int                               step_wait;
  int                               steps [2];    // Steps seen by the DUT so far
  int                               wraps [2];
  logic [stm_pkg::idx_width-1:0]    seen_idx [2];
  int                               err_cnt;
  int                               tmo_cnt;
  int                               cycle_cnt;

  stm_clkgen clkgen (
    .CLK   (CLK),
    .rst_n (rst_n)
  );

  stm_top uut (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .sys_time  (sys_time),
    .sync_idx0 (sync_idx0),
    .sync_idx1 (sync_idx1),
    .gpio_in   (gpio_in),
    .stop      (stop),
    .segment   (segment),
    .idx0      (idx0),
    .idx1      (idx1)
  );

  // ====================
  // Sequencer and time base
  // ====================
  always @(posedge CLK) begin
    #1;
    sys_time = sys_time + 1'b1;
    if (idx_run) begin
      if (step_wait == 0) begin
        step_wait = step_period - 1;
        sync_idx0 = (sync_idx0 == cycle0_val) ? '0 : sync_idx0 + 1'b1;
        sync_idx1 = (sync_idx1 == cycle1_val) ? '0 : sync_idx1 + 1'b1;
      end else begin
        step_wait--;
      end
    end
  end

  // Counts index changes at the edge where the DUT samples them
  always @(posedge CLK) begin : monitor
    logic [stm_pkg::idx_width-1:0] cur [2];
    cur[0] = sync_idx0;
    cur[1] = sync_idx1;
    for (int s = 0; s < 2; s++) begin
      if (cur[s] != seen_idx[s]) begin
        steps[s]++;
        if (cur[s] == '0) wraps[s]++;
      end
      seen_idx[s] = cur[s];
    end
  end

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] ctrl_word(input logic seg,
                                            input stm_pkg::transition_mode_t mode);
    return {21'b0, mode, 7'b0, seg};
  endfunction

  function automatic logic [31:0] status_word(input logic stp, input logic seg,
                                              input stm_pkg::swap_state_t st);
    logic [31:0] w;
    w      = '0;
    w[0]   = stp;
    w[1]   = seg;
    w[5:4] = st;  // State field
    return w;
  endfunction

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      err_cnt++;
      $display("Error at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge CLK);
    #1;
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(posedge CLK);  // Access edge
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge CLK);
    #1;
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(negedge CLK);  // Mid access phase
    data = prdata;
    err  = pslverr;
    check(pready === 1'b1, "pready low in an access phase");
    @(posedge CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
                            input string what);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check(data == exp && !err,
          $sformatf("%s reads 0x%0h with pslverr %0b, expected 0x%0h", what, data, err, exp));
  endtask

  task automatic wait_segment(input logic val, input string what);
    int n;
    n = 0;
    @(negedge CLK);
    while (segment !== val && n < wait_limit) begin
      @(negedge CLK);
      n++;
    end
    if (segment !== val) begin
      tmo_cnt++;
      $display("Timed out waiting for %s", what);
    end
  endtask

  task automatic wait_stop(input string what);
    int n;
    n = 0;
    @(negedge CLK);
    while (stop !== 1'b1 && n < wait_limit) begin
      @(negedge CLK);
      n++;
    end
    if (stop !== 1'b1) begin
      tmo_cnt++;
      $display("Timed out waiting for %s", what);
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
             err_cnt, tmo_cnt, uut.u_assert.fail_cnt);
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("Run stopped at the limit of %0d cycles before the tests ended", max_cycles);
    report_counts();
    $display("Simulation FAILED");
    $finish;
  end

  // ====================
  // Stimulus
  // ====================
  initial begin : stimulus
    logic [31:0]                    rd;
    logic                           err;
    int                             base;
    int                             sw_base;
    int                             n;
    int                             toggles;
    int                             last_wrap [2];
    logic                           exp_seg;
    logic [stm_pkg::time_width-1:0] t_trig;

    void'($urandom(26478));
    step_period = 2 + int'($urandom % 3);
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    sys_time  = '0;
    sync_idx0 = '0;
    sync_idx1 = '0;
    gpio_in   = 4'b0000;
    idx_run   = 1'b0;
    step_wait = 0;
    err_cnt   = 0;
    tmo_cnt   = 0;
    for (int s = 0; s < 2; s++) begin
      steps[s]    = 0;
      wraps[s]    = 0;
      seen_idx[s] = '0;
    end
    @(posedge rst_n);
    @(negedge CLK);

    // Register access
    apb_write(stm_pkg::addr_cycle0, cycle0_val);
    apb_write(stm_pkg::addr_cycle1, cycle1_val);
    apb_write(stm_pkg::addr_rep0, rep0_val);
    apb_write(stm_pkg::addr_rep1, rep1_val);
    read_check(stm_pkg::addr_cycle0, cycle0_val, "cycle0");
    read_check(stm_pkg::addr_cycle1, cycle1_val, "cycle1");
    read_check(stm_pkg::addr_rep0, rep0_val, "rep0");
    read_check(stm_pkg::addr_rep1, rep1_val, "rep1");
    apb_read(8'h30, rd, err);
    check(err === 1'b1, "no pslverr on a read of unmapped offset 0x30");
    read_check(stm_pkg::addr_status, status_word(1'b0, 1'b0, stm_pkg::infinite_loop),
               "status after reset");

    // Infinite repeat switches on the first edge after the access edge
    apb_write(stm_pkg::addr_rep1, 32'(stm_pkg::rep_infinite));
    apb_write(stm_pkg::addr_ctrl, ctrl_word(1'b1, stm_pkg::mode_sync_idx));
    @(negedge CLK);
    check(segment == 1'b0, "segment changed on the access edge");
    @(negedge CLK);
    check(segment == 1'b1 && stop == 1'b0,
          $sformatf("segment %0b stop %0b after infinite request, expected 1 and 0",
                    segment, stop));
    apb_write(stm_pkg::addr_rep1, rep1_val);

    // Sync-index trigger on segment 0
    apb_write(stm_pkg::addr_ctrl, ctrl_word(1'b0, stm_pkg::mode_sync_idx));
    @(negedge CLK);
    base    = wraps[0];
    idx_run = 1'b1;
    wait_segment(1'b0, "the sync-index switch to segment 0");
    check(wraps[0] - base == 1,
          $sformatf("segment switched after %0d wraps, expected 1", wraps[0] - base));
    sw_base = wraps[0];
    wait_stop("stop after the sync-index loops");
    check(wraps[0] - sw_base == rep0_val + 1,
          $sformatf("stop rose after %0d wraps, expected %0d", wraps[0] - sw_base,
                    rep0_val + 1));
    idx_run = 1'b0;
    read_check(stm_pkg::addr_status, status_word(1'b1, 1'b0, stm_pkg::finite_loop),
               "status after the finite loop");

    // System-time trigger on segment 1
    t_trig = sys_time + 30;
    apb_write(stm_pkg::addr_trans_lo, t_trig[31:0]);
    apb_write(stm_pkg::addr_trans_hi, 32'(t_trig[stm_pkg::time_width-1:32]));
    apb_write(stm_pkg::addr_ctrl, ctrl_word(1'b1, stm_pkg::mode_sys_time));
    @(negedge CLK);
    idx_run = 1'b1;
    wait_segment(1'b1, "the system-time switch to segment 1");
    check(sys_time >= t_trig && sys_time - t_trig <= 3,
          $sformatf("switch seen at sys_time %0d, trigger at %0d", sys_time, t_trig));
    sw_base = steps[1];
    n = 0;
    while (stop !== 1'b1 && n < wait_limit) begin
      check(idx1 == 13'((steps[1] - sw_base) % (cycle1_val + 1)),
            $sformatf("idx1 is %0d after %0d steps", idx1, steps[1] - sw_base));
      @(negedge CLK);
      n++;
    end
    if (stop !== 1'b1) begin
      tmo_cnt++;
      $display("Timed out waiting for stop in tic mode");
    end else begin
      check(steps[1] - sw_base == (rep1_val + 1) * (cycle1_val + 1),
            $sformatf("stop rose after %0d steps", steps[1] - sw_base));
    end
    idx_run = 1'b0;

    // GPIO trigger on segment 0, selected input is bit 2
    @(posedge CLK);
    #1;
    gpio_in = 4'b1011;
    apb_write(stm_pkg::addr_trans_lo, 32'd2);
    apb_write(stm_pkg::addr_ctrl, ctrl_word(1'b0, stm_pkg::mode_gpio));
    @(negedge CLK);
    idx_run = 1'b1;
    repeat (20) begin
      @(negedge CLK);
      check(segment == 1'b1, "segment switched while gpio_in[2] is low");
    end
    @(posedge CLK);
    #1;
    gpio_in = 4'b1111;
    @(negedge CLK);
    base = steps[0];
    wait_segment(1'b0, "the GPIO switch to segment 0");
    check(steps[0] - base == 1,
          $sformatf("GPIO switch after %0d steps, expected 1", steps[0] - base));
    wait_stop("stop after the GPIO loops");  // Stop high before the infinite request
    idx_run = 1'b0;

    // External mode ping-pong
    apb_write(stm_pkg::addr_rep0, 32'(stm_pkg::rep_infinite));
    apb_write(stm_pkg::addr_ctrl, ctrl_word(1'b0, stm_pkg::mode_ext));
    @(negedge CLK);
    @(negedge CLK);
    exp_seg      = 1'b0;
    toggles      = 0;
    last_wrap[0] = wraps[0];
    last_wrap[1] = wraps[1];
    idx_run      = 1'b1;
    repeat (80) begin
      @(negedge CLK);
      if (wraps[exp_seg] != last_wrap[exp_seg]) begin  // Wrap of the active segment
        exp_seg = ~exp_seg;
        toggles++;
      end
      last_wrap[0] = wraps[0];
      last_wrap[1] = wraps[1];
      check(segment == exp_seg && stop == 1'b0,
            $sformatf("segment %0b stop %0b, expected %0b and 0", segment, stop, exp_seg));
      check(idx0 == seen_idx[0] && idx1 == seen_idx[1],
            "index outputs do not follow the registered sync indices");
    end
    check(toggles >= 2, $sformatf("only %0d toggles in external mode", toggles));
    idx_run = 1'b0;

    @(negedge CLK);
    report_counts();
    if (err_cnt == 0 && tmo_cnt == 0 && uut.u_assert.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/stm_assert.sv
`timescale 1ns/1ns
`default_nettype none

module stm_assert (
  input logic                 CLK,
  input logic                 rst_n,
  input logic                 update,
  input logic                 psel,
  input logic                 penable,
  input logic                 pslverr,
  input logic                 segment,
  input logic                 stop,
  input stm_pkg::swap_state_t state
);

  int fail_cnt = 0;  // Read by the testbench for the closing report

  // ====================
  // Protocol properties
  // ====================
  update_one_cycle: assert property (
    @(posedge CLK) disable iff (!rst_n) update |=> !update
  ) else begin
    fail_cnt++;
    $error("update pulse lasted longer than one cycle");
  end

  // Segment moves outside finite_loop, or on an update with infinite repeat
  segment_on_trigger: assert property (
    @(posedge CLK) disable iff (!rst_n)
    $changed(segment) |-> ($past(state) != stm_pkg::finite_loop) || $past(update)
  ) else begin
    fail_cnt++;
    $error("segment changed during a finite loop without a trigger");
  end

  slverr_in_access: assert property (
    @(posedge CLK) pslverr |-> psel && penable
  ) else begin
    fail_cnt++;
    $error("pslverr raised outside an access phase");
  end

  stop_after_reset: assert property (
    @(posedge CLK) !rst_n |=> !stop
  ) else begin
    fail_cnt++;
    $error("stop is high after reset");
  end

endmodule

bind stm_top stm_assert u_assert (
  .CLK     (CLK),
  .rst_n   (rst_n),
  .update  (cfg_if.update),
  .psel    (psel),
  .penable (penable),
  .pslverr (pslverr),
  .segment (segment),
  .stop    (stop),
  .state   (state)
);

`default_nettype wire

// File: tb/stm_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module stm_clkgen (
  output logic CLK,
  output logic rst_n
);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;  // 100 ns period
  end

  // Reset held over the first two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge CLK);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/stm_top.sv
`timescale 1ns/1ns
`default_nettype none

module stm_top (
  input  logic                           CLK,
  input  logic                           rst_n,
  input  logic [7:0]                     paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  input  logic [stm_pkg::time_width-1:0] sys_time,
  input  logic [stm_pkg::idx_width-1:0]  sync_idx0,
  input  logic [stm_pkg::idx_width-1:0]  sync_idx1,
  input  logic [3:0]                     gpio_in,
  output logic                           stop,
  output logic                           segment,
  output logic [stm_pkg::idx_width-1:0]  idx0,
  output logic [stm_pkg::idx_width-1:0]  idx1
);

  logic [stm_pkg::num_segment-1:0] idx_step;
  logic [stm_pkg::num_segment-1:0] idx_wrap;
  logic [stm_pkg::idx_width-1:0]   tic_idx;
  logic                            time_reached;
  logic                            loop_done;
  logic                            counter_start;
  stm_pkg::idx_mode_t              idx_mode;
  stm_pkg::swap_state_t            state;

  assign pready = 1'b1;  // Zero wait states

  stm_cfg_if cfg_if ();

  stm_apb_regs u_regs (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .stop    (stop),
    .segment (segment),
    .state   (state),
    .cfg     (cfg_if.regs)
  );

  stm_idx_track u_idx (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .sync_idx0 (sync_idx0),
    .sync_idx1 (sync_idx1),
    .idx_mode  (idx_mode),
    .segment   (segment),
    .tic_idx   (tic_idx),
    .idx_step  (idx_step),
    .idx_wrap  (idx_wrap),
    .idx0      (idx0),
    .idx1      (idx1)
  );

  stm_time_trigger u_time (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .sys_time     (sys_time),
    .trans_time   (cfg_if.transition_value),
    .time_reached (time_reached)
  );

  stm_loop_counter u_cnt (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .cfg           (cfg_if.counter),
    .counter_start (counter_start),
    .idx_mode      (idx_mode),
    .segment       (segment),
    .idx_step      (idx_step),
    .idx_wrap      (idx_wrap),
    .tic_idx       (tic_idx),
    .loop_done     (loop_done)
  );

  stm_swap_fsm u_fsm (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .cfg           (cfg_if.fsm),
    .idx_step      (idx_step),
    .idx_wrap      (idx_wrap),
    .gpio_in       (gpio_in),
    .time_reached  (time_reached),
    .loop_done     (loop_done),
    .counter_start (counter_start),
    .idx_mode      (idx_mode),
    .segment       (segment),
    .stop          (stop),
    .state         (state)
  );

endmodule

`default_nettype wire

// File: logic/stm_swap_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module stm_swap_fsm (
  input  logic                            CLK,
  input  logic                            rst_n,
  stm_cfg_if.fsm                          cfg,
  input  logic [stm_pkg::num_segment-1:0] idx_step,
  input  logic [stm_pkg::num_segment-1:0] idx_wrap,
  input  logic [3:0]                      gpio_in,
  input  logic                            time_reached,
  input  logic                            loop_done,
  output logic                            counter_start,
  output stm_pkg::idx_mode_t              idx_mode,
  output logic                            segment,
  output logic                            stop,
  output stm_pkg::swap_state_t            state
);

  logic req_q;
  logic ext_mode;
  logic time_wait;  // Compare result is one cycle stale after update
  logic trigger;
  logic fire;
  logic req_infinite;

  assign req_infinite = cfg.rep[cfg.req_segment] == stm_pkg::rep_infinite;

  // ====================
  // Trigger select
  // ====================
  always_comb begin
    case (cfg.transition_mode)
      stm_pkg::mode_sync_idx: trigger = idx_wrap[req_q];
      stm_pkg::mode_sys_time: trigger = !time_wait && time_reached;
      stm_pkg::mode_gpio:     trigger = idx_step[req_q] && gpio_in[cfg.transition_value[1:0]];
      default:                trigger = 1'b0;
    endcase
  end

  assign fire          = (state == stm_pkg::wait_start) && !cfg.update && trigger;
  assign counter_start = fire;  // Counter clears on the switch edge

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state     <= stm_pkg::infinite_loop;
      segment   <= 1'b0;
      stop      <= 1'b0;
      idx_mode  <= stm_pkg::idx_mode_sync;
      ext_mode  <= 1'b0;
      req_q     <= 1'b0;
      time_wait <= 1'b0;
    end else if (cfg.update) begin
      if (req_infinite) begin
        segment  <= cfg.req_segment;
        stop     <= 1'b0;
        idx_mode <= stm_pkg::idx_mode_sync;
        ext_mode <= cfg.transition_mode == stm_pkg::mode_ext;
        state    <= stm_pkg::infinite_loop;
      end else begin
        req_q     <= cfg.req_segment;
        time_wait <= 1'b1;
        state     <= stm_pkg::wait_start;
      end
    end else begin
      time_wait <= 1'b0;
      case (state)
        stm_pkg::wait_start: begin
          if (fire) begin
            segment  <= req_q;
            stop     <= 1'b0;
            idx_mode <= (cfg.transition_mode == stm_pkg::mode_sync_idx) ?
                        stm_pkg::idx_mode_sync : stm_pkg::idx_mode_tic;
            state    <= stm_pkg::finite_loop;
          end
        end
        stm_pkg::finite_loop: begin
          if (loop_done) stop <= 1'b1;
        end
        stm_pkg::infinite_loop: begin
          if (ext_mode && idx_wrap[segment]) segment <= ~segment;  // Ping-pong
        end
        default: state <= stm_pkg::infinite_loop;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/stm_loop_counter.sv
`timescale 1ns/1ns
`default_nettype none

module stm_loop_counter (
  input  logic                            CLK,
  input  logic                            rst_n,
  stm_cfg_if.counter                      cfg,
  input  logic                            counter_start,
  input  stm_pkg::idx_mode_t              idx_mode,
  input  logic                            segment,
  input  logic [stm_pkg::num_segment-1:0] idx_step,
  input  logic [stm_pkg::num_segment-1:0] idx_wrap,
  output logic [stm_pkg::idx_width-1:0]   tic_idx,
  output logic                            loop_done
);

  logic [stm_pkg::rep_width-1:0] loop_cnt;
  logic                          done;  // Holds after the last loop
  logic                          tic_step;
  logic                          tic_last;
  logic                          loop_end;

  assign tic_step = (idx_mode == stm_pkg::idx_mode_tic) && idx_step[segment];
  assign tic_last = tic_idx == cfg.cycle[segment];
  assign loop_end = (idx_mode == stm_pkg::idx_mode_sync) ? idx_wrap[segment] :
                    (tic_step && tic_last);

  always_ff @(posedge CLK) begin
    if (!rst_n || counter_start) begin
      tic_idx   <= '0;
      loop_cnt  <= '0;
      done      <= 1'b0;
      loop_done <= 1'b0;
    end else begin
      loop_done <= 1'b0;
      if (tic_step) begin
        tic_idx <= tic_last ? '0 : tic_idx + 1'b1;
      end
      if (loop_end && !done) begin
        if (loop_cnt == cfg.rep[segment]) begin
          loop_done <= 1'b1;
          done      <= 1'b1;
        end else begin
          loop_cnt <= loop_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/stm_time_trigger.sv
`timescale 1ns/1ns
`default_nettype none

module stm_time_trigger (
  input  logic                           CLK,
  input  logic                           rst_n,
  input  logic [stm_pkg::time_width-1:0] sys_time,
  input  logic [stm_pkg::time_width-1:0] trans_time,
  output logic                           time_reached
);

  logic signed [stm_pkg::time_width:0] time_diff;

  assign time_diff = $signed({1'b0, sys_time}) - $signed({1'b0, trans_time});

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      time_reached <= 1'b0;
    end else begin
      time_reached <= !time_diff[stm_pkg::time_width];  // Non-negative difference
    end
  end

endmodule

`default_nettype wire

// File: logic/stm_idx_track.sv
`timescale 1ns/1ns
`default_nettype none

module stm_idx_track (
  input  logic                              CLK,
  input  logic                              rst_n,
  input  logic [stm_pkg::idx_width-1:0]     sync_idx0,
  input  logic [stm_pkg::idx_width-1:0]     sync_idx1,
  input  stm_pkg::idx_mode_t                idx_mode,
  input  logic                              segment,
  input  logic [stm_pkg::idx_width-1:0]     tic_idx,
  output logic [stm_pkg::num_segment-1:0]   idx_step,
  output logic [stm_pkg::num_segment-1:0]   idx_wrap,
  output logic [stm_pkg::idx_width-1:0]     idx0,
  output logic [stm_pkg::idx_width-1:0]     idx1
);

  logic [stm_pkg::num_segment-1:0][stm_pkg::idx_width-1:0] sync_in;
  logic [stm_pkg::num_segment-1:0][stm_pkg::idx_width-1:0] sync_q;
  logic [stm_pkg::num_segment-1:0][stm_pkg::idx_width-1:0] idx_out;

  assign sync_in = {sync_idx1, sync_idx0};

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= sync_in;
    end
  end

  for (genvar i = 0; i < stm_pkg::num_segment; i++) begin : g_seg
    assign idx_step[i] = sync_in[i] != sync_q[i];
    assign idx_wrap[i] = idx_step[i] && (sync_in[i] == '0);
    // Active segment follows the local tick index in tic mode
    assign idx_out[i]  = (idx_mode == stm_pkg::idx_mode_tic && segment == 1'(i)) ?
                         tic_idx : sync_q[i];
  end

  assign idx0 = idx_out[0];
  assign idx1 = idx_out[1];

endmodule

`default_nettype wire

// File: logic/stm_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module stm_apb_regs (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic [7:0]           paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pslverr,
  input  logic                 stop,
  input  logic                 segment,
  input  stm_pkg::swap_state_t state,
  stm_cfg_if.regs              cfg
);

  logic        mapped;
  logic        access;
  logic        wr_en;
  logic [31:0] rdata;

  assign access  = psel && penable;
  assign wr_en   = access && pwrite && mapped;
  assign pslverr = access && !mapped;

  // ====================
  // Address decode and read mux
  // ====================
  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (paddr)
      stm_pkg::addr_ctrl:     rdata = {21'b0, cfg.transition_mode, 7'b0, cfg.req_segment};
      stm_pkg::addr_trans_lo: rdata = cfg.transition_value[31:0];
      stm_pkg::addr_trans_hi: rdata = 32'(cfg.transition_value[stm_pkg::time_width-1:32]);
      stm_pkg::addr_cycle0:   rdata = 32'(cfg.cycle[0]);
      stm_pkg::addr_cycle1:   rdata = 32'(cfg.cycle[1]);
      stm_pkg::addr_rep0:     rdata = 32'(cfg.rep[0]);
      stm_pkg::addr_rep1:     rdata = 32'(cfg.rep[1]);
      stm_pkg::addr_status:   rdata = {26'b0, state, 2'b0, segment, stop};
      default:                mapped = 1'b0;
    endcase
  end

  // Read data is captured in the setup phase and held through access
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      prdata <= '0;
    end else if (psel && !penable && !pwrite) begin
      prdata <= rdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cfg.update          <= 1'b0;
      cfg.req_segment     <= 1'b0;
      cfg.transition_mode <= stm_pkg::mode_sync_idx;
    end else begin
      cfg.update <= wr_en && (paddr == stm_pkg::addr_ctrl);
      if (wr_en && (paddr == stm_pkg::addr_ctrl)) begin
        cfg.req_segment     <= pwdata[0];
        cfg.transition_mode <= stm_pkg::transition_mode_t'(pwdata[10:8]);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      case (paddr)
        stm_pkg::addr_trans_lo: cfg.transition_value[31:0] <= pwdata;
        stm_pkg::addr_trans_hi:
          cfg.transition_value[stm_pkg::time_width-1:32] <= pwdata[stm_pkg::time_width-33:0];
        stm_pkg::addr_cycle0:   cfg.cycle[0] <= pwdata[stm_pkg::idx_width-1:0];
        stm_pkg::addr_cycle1:   cfg.cycle[1] <= pwdata[stm_pkg::idx_width-1:0];
        stm_pkg::addr_rep0:     cfg.rep[0]   <= pwdata[stm_pkg::rep_width-1:0];
        stm_pkg::addr_rep1:     cfg.rep[1]   <= pwdata[stm_pkg::rep_width-1:0];
        default: ;  // Ctrl handled above, status is read only
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/stm_cfg_if.sv
`timescale 1ns/1ns
`default_nettype none

interface stm_cfg_if;

  logic                                  update;  // One-cycle pulse
  logic                                  req_segment;
  stm_pkg::transition_mode_t             transition_mode;
  logic [stm_pkg::time_width-1:0]        transition_value;
  logic [stm_pkg::num_segment-1:0][stm_pkg::idx_width-1:0] cycle;
  logic [stm_pkg::num_segment-1:0][stm_pkg::rep_width-1:0] rep;

  modport regs (output update, req_segment, transition_mode, transition_value, cycle, rep);

  modport fsm (input update, req_segment, transition_mode, transition_value, cycle, rep);

  modport counter (input cycle, rep);

endinterface

`default_nettype wire

// File: logic/stm_pkg.sv
`default_nettype none

package stm_pkg;

  // ====================
  // Segment geometry
  // ====================
  localparam int num_segment = 2;
  localparam int idx_width   = 13;
  localparam int rep_width   = 16;
  localparam int time_width  = 56;

  localparam logic [rep_width-1:0] rep_infinite = '1;  // Play forever

  // ====================
  // Register map
  // ====================
  localparam logic [7:0] addr_ctrl     = 8'h00;
  localparam logic [7:0] addr_trans_lo = 8'h04;
  localparam logic [7:0] addr_trans_hi = 8'h08;
  localparam logic [7:0] addr_cycle0   = 8'h10;
  localparam logic [7:0] addr_cycle1   = 8'h14;
  localparam logic [7:0] addr_rep0     = 8'h18;
  localparam logic [7:0] addr_rep1     = 8'h1C;
  localparam logic [7:0] addr_status   = 8'h20;

  typedef enum logic [2:0] {
    mode_sync_idx = 3'd0,
    mode_sys_time = 3'd1,
    mode_gpio     = 3'd2,
    mode_ext      = 3'd3   // Only with infinite repeat
  } transition_mode_t;

  typedef enum logic {
    idx_mode_sync = 1'b0,
    idx_mode_tic  = 1'b1
  } idx_mode_t;

  typedef enum logic [1:0] {
    wait_start    = 2'd0,
    finite_loop   = 2'd1,
    infinite_loop = 2'd2
  } swap_state_t;

endpackage

`default_nettype wire
